// ==== fetch_pkg.sv ====
/*
  Shared definitions for the instruction fetch front end.
  Vector typedefs for addresses, bus words and halfwords,
  the prefetch queue depth and the halfword mask constants.
*/
package fetch_pkg;

	// ----------------------------------------------------------
	// Vector types
	// ----------------------------------------------------------

	// Fetch addresses are full byte addresses but the bus only sees word-aligned ones
	typedef logic [31:0] addr_t;

	// One bus data word as returned by the memory
	typedef logic [31:0] word_t;

	// One instruction halfword, the unit of RVC alignment
	typedef logic [15:0] half_t;

	// Bit 0 flags the lower halfword of a word and bit 1 the upper one
	typedef logic [1:0] hw_mask_t;

	// Counts halfwords held in or consumed from the CIR, from 0 to 2
	typedef logic [1:0] hw_count_t;

	// Number of bus data phases still owed to the front end
	typedef logic [1:0] pend_t;

	// ----------------------------------------------------------
	// Constants
	// ----------------------------------------------------------

	// Two entries are enough to keep full throughput while decode stalls
	localparam int QUEUE_DEPTH = 2;

	// Width of one halfword in bits
	localparam int HW_BITS = 16;

	// Halfword mask values used by the request tracker, the queue and the aligner
	localparam hw_mask_t HW_NONE  = 2'b00;
	localparam hw_mask_t HW_UPPER = 2'b10;
	localparam hw_mask_t HW_ALL   = 2'b11;

endpackage

// ==== fetch_request.sv ====
/*
  Fetch request generation.
  Fetch address counter, address phase mux, jump acceptance,
  bus pipeline tracking and the flush counter for stale data.
*/
`timescale 1ns/10ps

module fetch_request import fetch_pkg::*; #(
	parameter addr_t reset_vector = 32'h0000_0000,
	parameter bit    ext_c        = 1'b1
) (
	input  logic       clk,
	input  logic       rst_n,
	output addr_t      mem_addr,
	output logic       mem_addr_vld,
	input  logic       mem_addr_rdy,
	input  logic       mem_data_vld,
	input  addr_t      jump_target,
	input  logic       jump_vld,
	output logic       jump_rdy,
	input  logic [1:0] queue_level,
	output logic       flush,
	output logic       fresh_vld,
	output hw_mask_t   fresh_hwvld
);

	addr_t fetch_addr;
	logic  reset_holdoff;
	logic  addr_hold;
	pend_t pending;
	pend_t pending_next;
	pend_t flush_ctr;
	logic  skip_lo;
	logic  jump_now;
	logic  aph_vld;
	logic  aph_accept;
	logic  fetch_stall;
	logic  queue_full;
	logic  queue_almost_full;

	// ----------------------------------------------------------
	// Address phase
	// ----------------------------------------------------------

	// A jump can only go through when no address phase is being held
	assign jump_rdy = !addr_hold;
	assign jump_now = jump_vld && jump_rdy;
	assign flush    = jump_now;

	// Registered pending count keeps bus ready out of the address phase path
	assign queue_full        = queue_level >= 2'(QUEUE_DEPTH);
	assign queue_almost_full = queue_level >= 2'(QUEUE_DEPTH - 1);
	assign fetch_stall       = queue_full || (queue_almost_full && pending != '0) ||
		pending > 2'd1;

	// Priority is a held address, then a jump, then a free-running fetch
	always_comb begin
		mem_addr = fetch_addr;
		aph_vld  = 1'b0;
		if (addr_hold) begin
			aph_vld = 1'b1;
		end else if (jump_now) begin
			mem_addr = {jump_target[31:2], 2'b00};
			// With two phases already owed the jump target waits in fetch_addr
			aph_vld  = pending < 2'd2;
		end else if (!fetch_stall) begin
			aph_vld = 1'b1;
		end
	end

	assign mem_addr_vld = aph_vld && !reset_holdoff;
	assign aph_accept   = mem_addr_vld && mem_addr_rdy;

	// Fetch address runs ahead of decode in word steps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			fetch_addr    <= {reset_vector[31:2], 2'b00};
		end else begin
			reset_holdoff <= 1'b0;
			if (jump_now) begin
				// Skip past the target word when it was accepted right away
				fetch_addr <= {jump_target[31:2] + 30'(aph_accept), 2'b00};
			end else if (aph_accept) begin
				fetch_addr <= fetch_addr + 32'd4;
			end
		end
	end

	// ----------------------------------------------------------
	// Bus pipeline tracking
	// ----------------------------------------------------------

	// A phase is counted when first presented since a held address cannot be withdrawn
	assign pending_next = pending + 2'(mem_addr_vld && !addr_hold) - 2'(mem_data_vld);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_hold <= 1'b0;
			pending   <= '0;
			flush_ctr <= '0;
		end else begin
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending   <= pending_next;
			// Every phase still owed at a jump returns stale data
			if (jump_now) begin
				flush_ctr <= pending - 2'(mem_data_vld);
			end else if (flush_ctr != '0 && mem_data_vld) begin
				flush_ctr <= flush_ctr - 2'd1;
			end
		end
	end

	// Data after the stale phases belongs to the current stream
	assign fresh_vld = mem_data_vld && flush_ctr == '0;

	// The first fresh word after a jump to an odd halfword lacks its lower half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			skip_lo <= ext_c && reset_vector[1];
		end else if (jump_now) begin
			skip_lo <= ext_c && jump_target[1];
		end else if (fresh_vld) begin
			skip_lo <= 1'b0;
		end
	end

	assign fresh_hwvld = skip_lo ? HW_UPPER : HW_ALL;

endmodule

// ==== prefetch_queue.sv ====
/*
  Prefetch queue between the bus and the instruction aligner.
  Compact shifting queue with halfword-valid masks, error bits
  and a bypass of fresh bus data to the head when empty.
*/
`timescale 1ns/10ps

module prefetch_queue import fetch_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       flush,
	input  logic       fresh_vld,
	input  hw_mask_t   fresh_hwvld,
	input  word_t      mem_data,
	input  logic       mem_data_err,
	input  logic       take,
	output word_t      head_data,
	output hw_mask_t   head_hwvld,
	output logic       head_err,
	output logic       head_vld,
	output logic [1:0] queue_level
);

	word_t                  q_data [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] q_err;
	hw_mask_t               q_hwvld [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] q_vld;
	word_t                  above_data [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] above_err;
	hw_mask_t               above_hwvld [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] above_vld;
	logic [QUEUE_DEPTH-1:0] below_vld;
	logic                   push;
	logic                   pop;

	// Each entry looks at its neighbours, the top one takes bus data instead
	for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_link
		assign q_vld[i] = |q_hwvld[i];
		if (i == QUEUE_DEPTH - 1) begin : g_top
			assign above_vld[i]   = 1'b0;
			assign above_data[i]  = mem_data;
			assign above_err[i]   = mem_data_err;
			assign above_hwvld[i] = HW_NONE;
		end else begin : g_mid
			assign above_vld[i]   = q_vld[i + 1];
			assign above_data[i]  = q_data[i + 1];
			assign above_err[i]   = q_err[i + 1];
			assign above_hwvld[i] = q_hwvld[i + 1];
		end
		if (i == 0) begin : g_bottom
			assign below_vld[i] = 1'b1;
		end else begin : g_upper
			assign below_vld[i] = q_vld[i - 1];
		end
	end

	// Fresh data goes straight to the aligner when the queue is empty and it has room
	assign pop  = take && q_vld[0];
	assign push = fresh_vld && !(take && !q_vld[0]);

	// Payload follows the shift and needs no reset
	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= above_vld[i] ? above_data[i] : mem_data;
				q_err[i]  <= above_vld[i] ? above_err[i] : mem_data_err;
			end
		end
	end

	// Valid masks keep the queue compact so entry 0 is always the oldest
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				q_hwvld[i] <= HW_NONE;
			end
		end else begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				if (flush) begin
					q_hwvld[i] <= HW_NONE;
				end else if (pop && above_vld[i]) begin
					q_hwvld[i] <= above_hwvld[i];
				end else if (pop && q_vld[i]) begin
					q_hwvld[i] <= push ? fresh_hwvld : HW_NONE;
				end else if (push && !pop && !q_vld[i] && below_vld[i]) begin
					q_hwvld[i] <= fresh_hwvld;
				end
			end
		end
	end

	always_comb begin
		queue_level = '0;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			queue_level = queue_level + 2'(q_vld[i]);
		end
	end

	// Head is the oldest entry or the bus word passing by
	assign head_data  = q_vld[0] ? q_data[0] : mem_data;
	assign head_hwvld = q_vld[0] ? q_hwvld[0] : fresh_hwvld;
	assign head_err   = q_vld[0] ? q_err[0] : mem_data_err;
	assign head_vld   = q_vld[0] || fresh_vld;

endmodule

// ==== instr_align.sv ====
/*
  Instruction assembly yard.
  Shifts consumed halfwords out of the CIR, aligns odd-start words
  and overlays the queue head where there is room.
*/
`timescale 1ns/10ps

module instr_align import fetch_pkg::*; #(
	parameter bit ext_c = 1'b1
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      flush,
	input  word_t     head_data,
	input  hw_mask_t  head_hwvld,
	input  logic      head_err,
	input  logic      head_vld,
	input  hw_count_t cir_use,
	output logic      take,
	output word_t     cir,
	output hw_count_t cir_vld,
	output hw_mask_t  cir_err
);

	// Level counts halfwords in {hwbuf, cir} and can reach 3
	logic [1:0]             level;
	logic [1:0]             level_nf;
	logic [1:0]             level_next;
	logic [1:0]             fill;
	half_t                  hwbuf;
	logic [2:0]             err_hw;
	logic [2:0]             err_shifted;
	logic [2:0]             err_next;
	word_t                  head_aligned;
	logic [3*HW_BITS-1:0]   data_shifted;
	logic [3*HW_BITS-1:0]   data_next;

	// ----------------------------------------------------------
	// Shift out what decode consumed
	// ----------------------------------------------------------

	// A word that starts on its upper half has that half moved down
	assign head_aligned = {
		head_data[HW_BITS +: HW_BITS],
		(head_hwvld[0] || !ext_c) ? head_data[0 +: HW_BITS] : head_data[HW_BITS +: HW_BITS]
	};

	// Slots that are later overwritten or ignored reuse hwbuf to save muxing
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[HW_BITS +: HW_BITS], hwbuf};
			err_shifted  = err_hw >> 2;
		end else if (cir_use[0] && ext_c) begin
			data_shifted = {hwbuf, hwbuf, cir[HW_BITS +: HW_BITS]};
			err_shifted  = err_hw >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted  = err_hw;
		end
	end

	assign level_nf = level - cir_use;

	// ----------------------------------------------------------
	// Overlay the queue head
	// ----------------------------------------------------------

	// A half-valid word needs only one free slot
	assign take = level_nf <= ((ext_c && head_hwvld != HW_ALL) ? 2'd2 : 2'd1);

	always_comb begin
		if (!take) begin
			data_next = data_shifted;
			err_next  = err_shifted;
		end else if (level_nf[1] && ext_c) begin
			data_next = {head_aligned[0 +: HW_BITS], data_shifted[0 +: 2*HW_BITS]};
			err_next  = {head_err, err_shifted[1:0]};
		end else if (level_nf[0] && ext_c) begin
			data_next = {head_aligned, data_shifted[0 +: HW_BITS]};
			err_next  = {{2{head_err}}, err_shifted[0]};
		end else begin
			data_next = {data_shifted[2*HW_BITS +: HW_BITS], head_aligned};
			err_next  = {err_shifted[2], {2{head_err}}};
		end
	end

	// Number of halfwords the head word adds
	assign fill = (take && head_vld) ? ((head_hwvld == HW_ALL) ? 2'd2 : 2'd1) : 2'd0;

	// A jump throws away everything held
	assign level_next = flush ? 2'd0 : level_nf + fill;

	// ----------------------------------------------------------
	// Registers
	// ----------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= '0;
			cir_vld <= '0;
			err_hw  <= '0;
		end else begin
			level   <= level_next;
			// Decode only sees the CIR so a level of 3 reports as 2
			cir_vld <= level_next & ~(level_next >> 1);
			err_hw  <= err_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err = err_hw[1:0];

endmodule

// ==== fetch_frontend.sv ====
/*
  Top level of the instruction fetch front end.
  Connects the request generator, the prefetch queue and the aligner.
*/
`timescale 1ns/10ps

module fetch_frontend import fetch_pkg::*; #(
	parameter addr_t reset_vector = 32'h0000_0000,
	parameter bit    ext_c        = 1'b1
) (
	input  logic      clk,
	input  logic      rst_n,

	// Pipelined fetch bus
	output addr_t     mem_addr,
	output logic      mem_addr_vld,
	input  logic      mem_addr_rdy,
	input  word_t     mem_data,
	input  logic      mem_data_err,
	input  logic      mem_data_vld,

	// Jump request from the core
	input  addr_t     jump_target,
	input  logic      jump_vld,
	output logic      jump_rdy,

	// Decode side of the CIR
	output word_t     cir,
	output hw_count_t cir_vld,
	input  hw_count_t cir_use,
	output hw_mask_t  cir_err
);

	logic       flush;
	logic       fresh_vld;
	hw_mask_t   fresh_hwvld;
	word_t      head_data;
	hw_mask_t   head_hwvld;
	logic       head_err;
	logic       head_vld;
	logic       take;
	logic [1:0] queue_level;

	// Address generation and bus tracking
	fetch_request #(
		.reset_vector (reset_vector),
		.ext_c        (ext_c)
	) u_request (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_addr     (mem_addr),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.mem_data_vld (mem_data_vld),
		.jump_target  (jump_target),
		.jump_vld     (jump_vld),
		.jump_rdy     (jump_rdy),
		.queue_level  (queue_level),
		.flush        (flush),
		.fresh_vld    (fresh_vld),
		.fresh_hwvld  (fresh_hwvld)
	);

	// Bus data is buffered here unless it can go straight to the CIR
	prefetch_queue u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.fresh_vld    (fresh_vld),
		.fresh_hwvld  (fresh_hwvld),
		.mem_data     (mem_data),
		.mem_data_err (mem_data_err),
		.take         (take),
		.head_data    (head_data),
		.head_hwvld   (head_hwvld),
		.head_err     (head_err),
		.head_vld     (head_vld),
		.queue_level  (queue_level)
	);

	instr_align #(
		.ext_c      (ext_c)
	) u_align (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.head_data  (head_data),
		.head_hwvld (head_hwvld),
		.head_err   (head_err),
		.head_vld   (head_vld),
		.cir_use    (cir_use),
		.take       (take),
		.cir        (cir),
		.cir_vld    (cir_vld),
		.cir_err    (cir_err)
	);

endmodule

// ==== fetch_frontend_props.sv ====
/*
  Assertions on the fetch front end.
  Bus pipeline depth, held address stability and the CIR level.
*/
`timescale 1ns/10ps

module fetch_frontend_props import fetch_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input pend_t     pending,
	input logic      addr_hold,
	input logic      mem_addr_vld,
	input addr_t     mem_addr,
	input hw_count_t cir_vld
);

	int fail_count;

	initial fail_count = 0;

	// No more than two data phases may be owed to the front end
	pending_limit: assert property (@(posedge clk) disable iff (!rst_n) pending <= 2'd2)
		else begin
			fail_count++;
			$error("pending fetch count above two");
		end

	// A held address phase keeps its valid and its address
	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		addr_hold |-> (mem_addr_vld && mem_addr == $past(mem_addr)))
		else begin
			fail_count++;
			$error("fetch address changed while held");
		end

	cir_limit: assert property (@(posedge clk) disable iff (!rst_n) cir_vld <= 2'd2)
		else begin
			fail_count++;
			$error("cir_vld above two halfwords");
		end

endmodule

bind fetch_request fetch_frontend_props u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.pending      (pending),
	.addr_hold    (addr_hold),
	.mem_addr_vld (mem_addr_vld),
	.mem_addr     (mem_addr),
	.cir_vld      (2'd0)
);

bind instr_align fetch_frontend_props u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.pending      (2'd0),
	.addr_hold    (1'b0),
	.mem_addr_vld (1'b0),
	.mem_addr     (32'd0),
	.cir_vld      (cir_vld)
);

// ==== tb_mem_image.svh ====
/*
  Memory image shared by the bus model and the checker.
  Halfword fill function, bus word assembly and the error range.
*/

// Halfwords in this range all carry the 32-bit length code
localparam addr_t RUN32_LO = 32'h0000_0100;
localparam addr_t RUN32_HI = 32'h0000_0180;

// Bus reads of words in this range return with the error flag set
localparam addr_t ERR_LO = 32'h0000_0800;
localparam addr_t ERR_HI = 32'h0000_0840;

// Every bit of the address feeds the hash so each halfword is distinct
function automatic half_t image_half(input addr_t addr);
	logic [31:0] x;
	x = addr * 32'h9e37_79b1;
	x = x ^ (x >> 13);
	x = x * 32'h85eb_ca6b;
	if (addr >= RUN32_LO && addr < RUN32_HI) begin
		return {x[31:18] ^ x[15:2], 2'b11};
	end
	return x[31:16] ^ x[15:0];
endfunction

function automatic word_t image_word(input addr_t addr);
	return {image_half({addr[31:2], 2'b10}), image_half({addr[31:2], 2'b00})};
endfunction

function automatic logic in_err_range(input addr_t addr);
	return addr >= ERR_LO && addr < ERR_HI;
endfunction

// ==== fetch_checker.sv ====
/*
  Checker for the fetch front end.
  Reference model of the instruction stream, reset checks,
  jump flush checks and the comparison of every consumed instruction.
*/
`timescale 1ns/10ps

module fetch_checker import fetch_pkg::*; #(
	parameter addr_t reset_vector = 32'h0000_0000
) (
	input  logic      clk,
	input  logic      rst_n,
	input  addr_t     mem_addr,
	input  logic      mem_addr_vld,
	input  logic      mem_addr_rdy,
	input  addr_t     jump_target,
	input  logic      jump_vld,
	input  logic      jump_rdy,
	input  word_t     cir,
	input  hw_count_t cir_vld,
	input  hw_count_t cir_use,
	input  hw_mask_t  cir_err,
	output int        err_count,
	output int        consume_count,
	output int        straddle_count,
	output int        err_instr_count,
	output logic      first_accept_seen
);

	`include "tb_mem_image.svh"

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------

	// Length follows the RISC-V rule, low bits 11 mean two halfwords
	function automatic hw_count_t ref_len(input addr_t pc);
		half_t lo;
		lo = image_half(pc);
		return (lo[1:0] == 2'b11) ? 2'd2 : 2'd1;
	endfunction

	function automatic word_t ref_instr(input addr_t pc);
		half_t lo;
		lo = image_half(pc);
		if (lo[1:0] == 2'b11) begin
			return {image_half(pc + 32'd2), lo};
		end
		return {16'h0000, lo};
	endfunction

	// Each halfword carries the error of the bus word it came from
	function automatic hw_mask_t ref_err(input addr_t pc, input hw_count_t len);
		return {len == 2'd2 && in_err_range(pc + 32'd2), in_err_range(pc)};
	endfunction

	// ----------------------------------------------------------
	// Comparison
	// ----------------------------------------------------------

	// Sampling on the falling edge sees settled DUT outputs
	initial begin : compare
		addr_t     exp_pc;
		word_t     exp_instr;
		word_t     mask;
		hw_count_t exp_len;
		hw_mask_t  exp_err;
		hw_mask_t  emask;
		logic      was_reset;
		logic      after_jump;
		err_count         = 0;
		consume_count     = 0;
		straddle_count    = 0;
		err_instr_count   = 0;
		first_accept_seen = 1'b0;
		exp_pc            = reset_vector;
		was_reset         = 1'b0;
		after_jump        = 1'b0;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				if (mem_addr_vld !== 1'b0 || cir_vld !== 2'd0) begin
					$display("Mismatch at %0t: fetch request or CIR active during reset",
						$time);
					err_count++;
				end
				was_reset = 1'b1;
			end else begin
				if (was_reset && (mem_addr_vld !== 1'b0 || cir_vld !== 2'd0)) begin
					$display("Mismatch at %0t: fetch request or CIR active right after reset",
						$time);
					err_count++;
				end
				was_reset = 1'b0;
				// The CIR must be empty on the cycle after a jump was taken
				if (after_jump && cir_vld != 2'd0) begin
					$display("Mismatch at %0t: CIR still holds data after a jump", $time);
					err_count++;
				end
				after_jump = 1'b0;
				if (!first_accept_seen && mem_addr_vld && mem_addr_rdy) begin
					first_accept_seen = 1'b1;
					if (mem_addr != reset_vector) begin
						$display("Mismatch at %0t: first fetch address %h, expected %h",
							$time, mem_addr, reset_vector);
						err_count++;
					end
				end
				if (cir_use != 2'd0) begin
					exp_len   = ref_len(exp_pc);
					exp_instr = ref_instr(exp_pc);
					exp_err   = ref_err(exp_pc, exp_len);
					mask      = (exp_len == 2'd2) ? 32'hffff_ffff : 32'h0000_ffff;
					emask     = (exp_len == 2'd2) ? 2'b11 : 2'b01;
					if (cir_use != exp_len) begin
						$display("Mismatch at %0t: length at %h is %0d, expected %0d",
							$time, exp_pc, cir_use, exp_len);
						err_count++;
					end else if ((cir & mask) != exp_instr) begin
						$display("Mismatch at %0t: instruction at %h is %h, expected %h",
							$time, exp_pc, cir & mask, exp_instr);
						err_count++;
					end else if ((cir_err & emask) != exp_err) begin
						$display("Mismatch at %0t: error flags at %h are %b, expected %b",
							$time, exp_pc, cir_err & emask, exp_err);
						err_count++;
					end
					if (exp_len == 2'd2 && exp_pc[1]) begin
						straddle_count++;
					end
					if (exp_err != 2'b00) begin
						err_instr_count++;
					end
					consume_count++;
					exp_pc = exp_pc + {29'd0, exp_len, 1'b0};
				end
				// Consume in a jump cycle still belongs to the old stream
				if (jump_vld && jump_rdy) begin
					exp_pc     = jump_target;
					after_jump = 1'b1;
				end
			end
		end
	end

endmodule

// ==== tb_fetch_frontend.sv ====
/*
  Testbench top for the fetch front end.
  Clock, reset, bus memory model, decode consumer and test sequence.
*/
`timescale 1ns/10ps

module tb_fetch_frontend import fetch_pkg::*; ();

	`include "tb_mem_image.svh"

	localparam addr_t RESET_VECTOR   = 32'h0000_0100;
	localparam int    DRIVE_DELAY    = 1;
	localparam int    TIMEOUT_CYCLES = 2000;

	// Word and odd halfword targets, first half calm and second half random
	localparam addr_t JUMP_LIST [8] = '{
		32'h0000_0400, 32'h0000_0522, 32'h0000_010a, 32'h0000_06f6,
		32'h0000_0300, 32'h0000_07fe, 32'h0000_09a2, 32'h0000_0c40
	};

	logic      clk;
	logic      rst_n;
	addr_t     mem_addr;
	logic      mem_addr_vld;
	logic      mem_addr_rdy;
	word_t     mem_data;
	logic      mem_data_err;
	logic      mem_data_vld;
	addr_t     jump_target;
	logic      jump_vld;
	logic      jump_rdy;
	word_t     cir;
	hw_count_t cir_vld;
	hw_count_t cir_use;
	hw_mask_t  cir_err;

	int        err_count;
	int        consume_count;
	int        straddle_count;
	int        err_instr_count;
	logic      first_accept_seen;

	logic        chaos;
	logic [31:0] rng;
	addr_t       pend_addr [$];
	int          pend_due [$];
	int          tests_run;
	int          tests_failed;

	fetch_frontend #(
		.reset_vector (RESET_VECTOR),
		.ext_c        (1'b1)
	) DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_addr     (mem_addr),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.mem_data     (mem_data),
		.mem_data_err (mem_data_err),
		.mem_data_vld (mem_data_vld),
		.jump_target  (jump_target),
		.jump_vld     (jump_vld),
		.jump_rdy     (jump_rdy),
		.cir          (cir),
		.cir_vld      (cir_vld),
		.cir_use      (cir_use),
		.cir_err      (cir_err)
	);

	fetch_checker #(
		.reset_vector (RESET_VECTOR)
	) u_checker (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_addr          (mem_addr),
		.mem_addr_vld      (mem_addr_vld),
		.mem_addr_rdy      (mem_addr_rdy),
		.jump_target       (jump_target),
		.jump_vld          (jump_vld),
		.jump_rdy          (jump_rdy),
		.cir               (cir),
		.cir_vld           (cir_vld),
		.cir_use           (cir_use),
		.cir_err           (cir_err),
		.err_count         (err_count),
		.consume_count     (consume_count),
		.straddle_count    (straddle_count),
		.err_instr_count   (err_instr_count),
		.first_accept_seen (first_accept_seen)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ----------------------------------------------------------
	// Bus memory model and decode consumer
	// ----------------------------------------------------------

	initial begin : bus_and_decode
		logic      acc;
		addr_t     acc_addr;
		addr_t     rd_addr;
		hw_count_t len;
		logic      stall;
		int        cycle;
		cycle = 0;
		rng   = 32'd55309;
		forever begin
			@(negedge clk);
			acc      = rst_n && mem_addr_vld && mem_addr_rdy;
			acc_addr = mem_addr;
			@(posedge clk);
			#DRIVE_DELAY;
			cycle++;
			rng = xorshift32(rng);
			// Read data follows one or two cycles after the address, in order
			if (acc) begin
				pend_addr.push_back(acc_addr);
				pend_due.push_back(cycle + int'(rng[0]));
			end
			if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
				rd_addr = pend_addr.pop_front();
				void'(pend_due.pop_front());
				mem_data     = image_word(rd_addr);
				mem_data_err = in_err_range(rd_addr);
				mem_data_vld = 1'b1;
			end else begin
				mem_data_err = 1'b0;
				mem_data_vld = 1'b0;
			end
			mem_addr_rdy = !chaos || rng[3:2] != 2'b00;
			// Decode takes the instruction in cir once all of it is there
			len     = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
			stall   = chaos && rng[7:6] == 2'b00;
			cir_use = (!stall && cir_vld >= len) ? len : 2'd0;
		end
	end

	// ----------------------------------------------------------
	// Sequence helpers
	// ----------------------------------------------------------

	task automatic wait_first_accept(output bit ok);
		int waited;
		waited = 0;
		while (!first_accept_seen && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		ok = first_accept_seen;
		if (!ok) begin
			$display("Timeout at %0t: no fetch address was accepted after reset", $time);
		end
	endtask

	task automatic wait_consumed(input int count, output bit ok);
		int target;
		int waited;
		target = consume_count + count;
		waited = 0;
		while (consume_count < target && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		ok = consume_count >= target;
		if (!ok) begin
			$display("Timeout at %0t: decode got only %0d of %0d instructions",
				$time, count - (target - consume_count), count);
		end
	endtask

	// Jump request is held until the front end accepts it
	task automatic take_jump(input addr_t target, output bit ok);
		int waited;
		@(posedge clk);
		#DRIVE_DELAY;
		jump_target = target;
		jump_vld    = 1'b1;
		ok          = 1'b0;
		waited      = 0;
		while (!ok && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			if (jump_rdy) begin
				ok = 1'b1;
			end else begin
				waited++;
			end
		end
		@(posedge clk);
		#DRIVE_DELAY;
		jump_vld = 1'b0;
		if (!ok) begin
			$display("Timeout at %0t: jump to %h was never accepted", $time, target);
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs_before,
		input bit ok);
		tests_run++;
		if (ok && err_count == errs_before) begin
			$display("Test %0d %s: PASS", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAIL with %0d errors", num, name, err_count - errs_before);
		end
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------

	initial begin : test_sequence
		int errs_before;
		int cnt_before;
		int asrt_fails;
		bit ok;
		bit step_ok;
		mem_addr_rdy = 1'b0;
		mem_data     = '0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		jump_target  = '0;
		jump_vld     = 1'b0;
		cir_use      = 2'd0;
		chaos        = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		rst_n        = 1'b0;
		repeat (16) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		wait_first_accept(ok);
		report_test(1, "reset and first fetch", 0, ok);

		// Reset vector sits in the all 32-bit region
		errs_before = err_count;
		wait_consumed(20, ok);
		report_test(2, "sequential 32-bit run", errs_before, ok);

		errs_before = err_count;
		cnt_before  = straddle_count;
		wait_consumed(60, ok);
		if (straddle_count == cnt_before) begin
			$display("No 32-bit instruction straddled a word boundary");
			ok = 1'b0;
		end
		report_test(3, "mixed 16/32-bit run", errs_before, ok);

		errs_before = err_count;
		ok          = 1'b1;
		for (int i = 0; i < 4; i++) begin
			take_jump(JUMP_LIST[i], step_ok);
			ok = ok && step_ok;
			wait_consumed(8, step_ok);
			ok = ok && step_ok;
		end
		report_test(4, "jumps to word and halfword targets", errs_before, ok);

		// Start just below the error range and run through it
		errs_before = err_count;
		cnt_before  = err_instr_count;
		take_jump(ERR_LO - 32'd8, ok);
		wait_consumed(40, step_ok);
		ok = ok && step_ok;
		if (err_instr_count == cnt_before) begin
			$display("No instruction from the error range reached decode");
			ok = 1'b0;
		end
		report_test(5, "bus error flags", errs_before, ok);

		errs_before = err_count;
		@(negedge clk);
		chaos = 1'b1;
		ok    = 1'b1;
		for (int i = 4; i < 8; i++) begin
			take_jump(JUMP_LIST[i], step_ok);
			ok = ok && step_ok;
			wait_consumed(60, step_ok);
			ok = ok && step_ok;
		end
		report_test(6, "random bus ready and decode stalls", errs_before, ok);

		asrt_fails = DUT.u_request.u_props.fail_count + DUT.u_align.u_props.fail_count;
		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_count, asrt_fails);
		if (tests_failed == 0 && err_count == 0 && asrt_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
fetch_pkg.sv
fetch_request.sv
prefetch_queue.sv
instr_align.sv
fetch_frontend.sv
fetch_frontend_props.sv
fetch_checker.sv
tb_fetch_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="Simulation completed successfully"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_fetch_frontend -o sim_fetch_frontend
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_fetch_frontend +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "$PASS_MSG" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
